// ==== Makefile ====
TOP = tb_spi_ctrl

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only --timing --assert -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+common
common/spi_pkg.sv
common/axil_pkg.sv
spi/spi_tx_shifter.sv
spi/spi_rx_sampler.sv
spi/spi_engine.sv
logic/axil_spi_regs.sv
logic/spi_ctrl_top.sv
sim/spi_slave_model.sv
sim/tb_spi_ctrl.sv

// ==== common/axil_pkg.sv ====
package axil_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  typedef struct packed {
    logic       valid;
    logic [3:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } axil_w_t;

  // Write strobes are not carried; every write is a full word.

  typedef struct packed {
    logic       valid;
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic        valid;
    axil_resp_e  resp;
    logic [31:0] data;
  } axil_r_t;

endpackage

// ==== common/spi_cfg.svh ====
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// Frame layout. The address field takes the bits between the write flag and the data.
`define SPI_CMD_WIDTH  12
`define SPI_READ_WIDTH 8

`define SPI_SCLK_DIV   4     // clk cycles per half sclk period.

// Register byte offsets on the 4-bit AXI4-Lite address.
`define SPI_REG_CMD    4'h0
`define SPI_REG_STATUS 4'h4
`define SPI_REG_RDATA  4'h8

`endif

// ==== common/spi_pkg.sv ====
`include "spi_cfg.svh"

package spi_pkg;

  // Frame sequencer states.
  typedef enum logic [2:0] {
    IDLE,   // cs high, waiting for a command.
    SETUP,  // cs low, first bit already on mosi.
    SEND,   // Command frame shifts out.
    RECV,   // Read byte shifts in.
    HOLD    // Last half period with cs still low.
  } spi_state_e;

  // Command word as software writes it.
  typedef struct packed {
    logic                                      write;  // 1 writes the slave, 0 reads it.
    logic [`SPI_CMD_WIDTH-`SPI_READ_WIDTH-2:0] addr;
    logic [`SPI_READ_WIDTH-1:0]                data;
  } spi_cmd_t;

  // One-cycle pulses from the engine to the shifter and the sampler.
  typedef struct packed {
    logic load;
    logic shift;
    logic sample;
  } spi_strobe_t;

endpackage

// ==== logic/axil_spi_regs.sv ====
`include "spi_cfg.svh"

module axil_spi_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  axil_pkg::axil_aw_t         aw,
  input  axil_pkg::axil_w_t          w,
  output logic                       awready,
  output logic                       wready,
  output axil_pkg::axil_b_t          b,
  input  logic                       bready,
  input  axil_pkg::axil_ar_t         ar,
  output logic                       arready,
  output axil_pkg::axil_r_t          r,
  input  logic                       rready,
  output logic                       cmd_start,
  output spi_pkg::spi_cmd_t          cmd,
  input  logic                       busy,
  input  logic                       done_pulse,
  input  logic [`SPI_READ_WIDTH-1:0] rd_byte
);
  import axil_pkg::*;

  logic                       wr_fire;
  logic                       rd_fire;
  logic                       cmd_hit;
  logic                       refuse;
  logic                       start_ok;
  logic                       rd_valid;
  logic [`SPI_READ_WIDTH-1:0] rdata_q;
  logic [31:0]                rd_mux;

  // AW and W are taken together, and only with no B response outstanding.
  assign wr_fire  = aw.valid && w.valid && !b.valid;
  assign awready  = wr_fire;
  assign wready   = wr_fire;
  assign rd_fire  = ar.valid && !r.valid;
  assign arready  = rd_fire;

  assign cmd_hit  = (aw.addr == `SPI_REG_CMD);
  assign refuse   = busy || cmd_start;  // A start in flight counts as busy.
  assign start_ok = wr_fire && cmd_hit && !refuse;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      b         <= '0;
      cmd_start <= 1'b0;
      rd_valid  <= 1'b0;
    end
    else
    begin
      cmd_start <= start_ok;
      if (wr_fire)
      begin
        b.valid <= 1'b1;
        b.resp  <= (cmd_hit && refuse) ? SLVERR : OKAY;
      end
      else if (bready)
        b.valid <= 1'b0;
      // cmd stays put for the whole frame, so its write flag tells the frame direction.
      if (done_pulse && !cmd.write)
        rd_valid <= 1'b1;
      else if (rd_fire && (ar.addr == `SPI_REG_RDATA))
        rd_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_ok)
      cmd <= w.data[`SPI_CMD_WIDTH-1:0];
    if (done_pulse && !cmd.write)
      rdata_q <= rd_byte;
  end

  // CMD is write-only and reads back as zero like any unmapped offset.
  always_comb
  begin
    case (ar.addr)
      `SPI_REG_STATUS: rd_mux = {30'd0, rd_valid, busy};
      `SPI_REG_RDATA:  rd_mux = {{(32 - `SPI_READ_WIDTH){1'b0}}, rdata_q};
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      r <= '0;
    else if (rd_fire)
    begin
      r.valid <= 1'b1;
      r.resp  <= OKAY;
      r.data  <= rd_mux;
    end
    else if (rready)
      r.valid <= 1'b0;
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b.valid && !bready |=> b.valid && $stable(b));
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r.valid && !rready |=> r.valid && $stable(r));

endmodule

// ==== logic/spi_ctrl_top.sv ====
`include "spi_cfg.svh"

module spi_ctrl_top (
  input  logic               clk,
  input  logic               rst_n,
  input  axil_pkg::axil_aw_t aw,
  input  axil_pkg::axil_w_t  w,
  output logic               awready,
  output logic               wready,
  output axil_pkg::axil_b_t  b,
  input  logic               bready,
  input  axil_pkg::axil_ar_t ar,
  output logic               arready,
  output axil_pkg::axil_r_t  r,
  input  logic               rready,
  output logic               sclk,
  output logic               cs,
  output logic               mosi,
  input  logic               miso
);
  import spi_pkg::*;

  logic                       cmd_start;
  spi_cmd_t                   cmd;
  logic                       busy;
  logic                       done_pulse;
  logic [`SPI_READ_WIDTH-1:0] rd_byte;

  axil_spi_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .aw         (aw),
    .w          (w),
    .awready    (awready),
    .wready     (wready),
    .b          (b),
    .bready     (bready),
    .ar         (ar),
    .arready    (arready),
    .r          (r),
    .rready     (rready),
    .cmd_start  (cmd_start),
    .cmd        (cmd),
    .busy       (busy),
    .done_pulse (done_pulse),
    .rd_byte    (rd_byte)
  );

  spi_engine u_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_start  (cmd_start),
    .cmd        (cmd),
    .busy       (busy),
    .done_pulse (done_pulse),
    .rd_byte    (rd_byte),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso)
  );

endmodule

// ==== sim/spi_slave_model.sv ====
`include "spi_cfg.svh"

module spi_slave_model (
  input  logic                      sclk,
  input  logic                      cs,
  input  logic                      mosi,
  output logic                      miso,
  output logic [`SPI_CMD_WIDTH-1:0] last_frame,
  output int                        frame_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`SPI_READ_WIDTH-1:0] mem [8];
  logic [`SPI_CMD_WIDTH-1:0]  rx_shift;
  logic [`SPI_READ_WIDTH-1:0] tx_shift;
  int                         rise_cnt;

  initial
  begin
    miso       = 1'b0;
    last_frame = '0;
    frame_cnt  = 0;
    rise_cnt   = 0;
    rx_shift   = '0;
    tx_shift   = '0;
    for (int i = 0; i < 8; i++)
      mem[i] = '0;
  end

  always @(negedge cs)
  begin
    rise_cnt = 0;
    rx_shift = '0;
  end

  always @(posedge sclk)
  begin
    if (!cs && (rise_cnt < `SPI_CMD_WIDTH))
    begin
      rx_shift = {rx_shift[`SPI_CMD_WIDTH-2:0], mosi};  // Mode 0 takes mosi on the rising edge.
      rise_cnt = rise_cnt + 1;
      if (rise_cnt == `SPI_CMD_WIDTH)
      begin
        last_frame = rx_shift;
        frame_cnt  = frame_cnt + 1;
        if (rx_shift[`SPI_CMD_WIDTH-1])
          mem[rx_shift[10:8]] = rx_shift[`SPI_READ_WIDTH-1:0];
        else
          tx_shift = mem[rx_shift[10:8]];
      end
    end
  end

  // The falling edge that ends a read command puts the MSB on miso.
  always @(negedge sclk)
  begin
    if (!cs && (rise_cnt == `SPI_CMD_WIDTH) && !rx_shift[`SPI_CMD_WIDTH-1])
    begin
      miso     = tx_shift[`SPI_READ_WIDTH-1];
      tx_shift = {tx_shift[`SPI_READ_WIDTH-2:0], 1'b0};
    end
  end

endmodule

// ==== sim/tb_spi_ctrl.sv ====
`include "spi_cfg.svh"

module tb_spi_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import axil_pkg::*;
  import spi_pkg::*;

  // One half period of setup and one of hold around 12 full sclk periods.
  localparam int WR_LOW_CYCLES  = (2 * `SPI_CMD_WIDTH + 2) * `SPI_SCLK_DIV;
  localparam int RD_LOW_CYCLES  = WR_LOW_CYCLES + 2 * `SPI_READ_WIDTH * `SPI_SCLK_DIV;
  localparam int TIMEOUT_CYCLES = 20 * 200 + 1000;  // 20 frames of 200 cycles plus margin.

  logic                      clk;
  logic                      rst_n;
  axil_aw_t                  aw;
  axil_w_t                   w;
  logic                      awready;
  logic                      wready;
  axil_b_t                   b;
  logic                      bready;
  axil_ar_t                  ar;
  logic                      arready;
  axil_r_t                   r;
  logic                      rready;
  logic                      sclk;
  logic                      cs;
  logic                      mosi;
  logic                      miso;
  logic [`SPI_CMD_WIDTH-1:0] last_frame;
  int                        slave_frames;

  int                         seed = 32'ha4a3;
  int                         cycles = 0;
  int                         frames_sent;
  int                         cs_rises;
  int                         cs_low_cnt;
  logic                       cs_q;
  int                         exp_low;
  spi_cmd_t                   exp_frame;
  axil_resp_e                 exp_resp;
  logic [31:0]                exp_rdata;
  logic [`SPI_READ_WIDTH-1:0] ref_regs [8];

  spi_ctrl_top DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .aw      (aw),
    .w       (w),
    .awready (awready),
    .wready  (wready),
    .b       (b),
    .bready  (bready),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready),
    .sclk    (sclk),
    .cs      (cs),
    .mosi    (mosi),
    .miso    (miso)
  );

  spi_slave_model u_slave (
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .last_frame (last_frame),
    .frame_cnt  (slave_frames)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES)
      abort_run("timeout, the run did not finish within the cycle limit");
  end

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs_q       <= 1'b1;
      cs_low_cnt <= 0;
      cs_rises   <= 0;
    end
    else
    begin
      cs_q       <= cs;
      cs_low_cnt <= cs ? 0 : cs_low_cnt + 1;
      if (cs && !cs_q)
        cs_rises <= cs_rises + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("TB FAILED");
    $display("mismatch at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    $fatal(1, "stopped at the first error");
  endtask

  task automatic abort_run(input string what);
    $display("TB FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input axil_resp_e resp);
    int stall;
    stall = $random(seed) & 3;
    @(posedge clk);
    exp_resp <= resp;
    aw.valid <= 1'b1;
    aw.addr  <= addr;
    w.valid  <= 1'b1;
    w.data   <= data;
    @(negedge clk);
    while (!(awready && wready))
      @(negedge clk);
    @(posedge clk);
    aw.valid <= 1'b0;
    w.valid  <= 1'b0;
    repeat (stall)
      @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    while (!b.valid)
      @(negedge clk);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, input logic [31:0] data);
    int stall;
    stall = $random(seed) & 3;
    @(posedge clk);
    exp_rdata <= data;
    ar.valid  <= 1'b1;
    ar.addr   <= addr;
    @(negedge clk);
    while (!arready)
      @(negedge clk);
    @(posedge clk);
    ar.valid <= 1'b0;
    repeat (stall)
      @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    while (!r.valid)
      @(negedge clk);
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic send_frame(input spi_cmd_t c);
    exp_frame   <= c;
    exp_low     <= c.write ? WR_LOW_CYCLES : RD_LOW_CYCLES;
    frames_sent <= frames_sent + 1;
    write_reg(`SPI_REG_CMD, {20'd0, c}, OKAY);
  endtask

  task automatic wait_frames();
    @(negedge clk);
    while (cs_rises != frames_sent)
      @(negedge clk);
  endtask

  initial
  begin
    logic [31:0] rnd;
    spi_cmd_t    c;
    rst_n       = 1'b0;
    aw          = '0;
    w           = '0;
    ar          = '0;
    bready      = 1'b0;
    rready      = 1'b0;
    frames_sent = 0;
    exp_low     = 0;
    exp_frame   = '0;
    exp_resp    = OKAY;
    exp_rdata   = '0;
    for (int i = 0; i < 8; i++)
      ref_regs[i] = '0;
    repeat (4)
      @(posedge clk);
    rst_n <= 1'b1;

    read_reg(`SPI_REG_STATUS, 32'h0);

    repeat (8)
    begin
      rnd              = $random(seed);
      c                = rnd[`SPI_CMD_WIDTH-1:0];
      c.write          = 1'b1;
      ref_regs[c.addr] = c.data;
      send_frame(c);
      wait_frames();
    end

    for (int a = 0; a < 8; a++)
    begin
      rnd     = $random(seed);
      c       = rnd[`SPI_CMD_WIDTH-1:0];
      c.write = 1'b0;
      c.addr  = a[2:0];
      send_frame(c);
      wait_frames();
      read_reg(`SPI_REG_STATUS, 32'h2);
      read_reg(`SPI_REG_RDATA, {24'd0, ref_regs[a]});
      read_reg(`SPI_REG_STATUS, 32'h0);
    end

    // The second command lands while the first frame is still on the wire.
    rnd     = $random(seed);
    c       = rnd[`SPI_CMD_WIDTH-1:0];
    c.write = 1'b1;
    send_frame(c);
    read_reg(`SPI_REG_STATUS, 32'h1);
    rnd = $random(seed);
    write_reg(`SPI_REG_CMD, {20'd0, rnd[`SPI_CMD_WIDTH-1:0]}, SLVERR);
    wait_frames();
    repeat (WR_LOW_CYCLES + 2 * `SPI_SCLK_DIV)  // Room for a refused frame to show up.
      @(negedge clk);

    if (slave_frames != frames_sent)
      report_mismatch("slave frame count", slave_frames, frames_sent);
    else
    begin
      $display("TB PASSED");
      $finish;
    end
  end

  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> cs && !sclk && !b.valid && !r.valid)
    else abort_run("cs, sclk or a response valid is not idle right after reset");
  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
    else abort_run("sclk is high while cs is high");
  a_sclk_cs: assert property (@(posedge clk) disable iff (!rst_n)
    (sclk != $past(sclk)) |-> !cs && !$past(cs))
    else abort_run("sclk toggled while cs was high");
  a_frame: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cs) |-> last_frame == exp_frame)
    else report_mismatch("last_frame", $sampled(last_frame), $sampled(exp_frame));
  a_frame_cnt: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cs) |-> slave_frames == frames_sent)
    else report_mismatch("slave_frames", $sampled(slave_frames), $sampled(frames_sent));
  a_cs_len: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cs) |-> cs_low_cnt == exp_low)
    else report_mismatch("cs low cycles", $sampled(cs_low_cnt), $sampled(exp_low));
  a_bresp: assert property (@(posedge clk) disable iff (!rst_n)
    b.valid && bready |-> b.resp == exp_resp)
    else report_mismatch("b.resp", $sampled(b.resp), $sampled(exp_resp));
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    r.valid && rready |-> r.data == exp_rdata && r.resp == OKAY)
    else report_mismatch("r.data", $sampled(r.data), $sampled(exp_rdata));
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b.valid && !bready |=> b.valid && (b == $past(b)))
    else abort_run("b channel dropped or changed before bready");
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r.valid && !rready |=> r.valid && (r == $past(r)))
    else abort_run("r channel dropped or changed before rready");

endmodule

// ==== spi/spi_engine.sv ====
`include "spi_cfg.svh"

module spi_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_start,
  input  spi_pkg::spi_cmd_t          cmd,
  output logic                       busy,
  output logic                       done_pulse,
  output logic [`SPI_READ_WIDTH-1:0] rd_byte,
  output logic                       sclk,
  output logic                       cs,
  output logic                       mosi,
  input  logic                       miso
);
  import spi_pkg::*;

  localparam int CNT_W = (`SPI_SCLK_DIV > 1) ? $clog2(`SPI_SCLK_DIV) : 1;

  spi_state_e       state;
  spi_state_e       state_nxt;
  logic [CNT_W-1:0] half_cnt;
  logic             half_end;
  logic             rise;
  logic             fall;
  logic             wr_frame;
  logic             tx_last;
  logic             rx_full;
  spi_strobe_t      strobe;

  assign half_end = (half_cnt == CNT_W'(`SPI_SCLK_DIV - 1));

  // SETUP ends without an edge, so each bit gets a low and then a high half period.
  assign rise = half_end && (state inside {SEND, RECV}) && !sclk;
  assign fall = half_end && (state inside {SEND, RECV}) && sclk;

  assign strobe.load   = cmd_start && (state == IDLE);
  assign strobe.shift  = fall;              // Mode 0 changes mosi on the falling edge.
  assign strobe.sample = rise && (state == RECV);

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
        if (cmd_start)
          state_nxt = SETUP;
      SETUP:
        if (half_end)
          state_nxt = SEND;
      SEND:
        if (fall && tx_last)
          state_nxt = wr_frame ? HOLD : RECV;
      RECV:
        if (fall && rx_full)
          state_nxt = HOLD;
      HOLD:
        if (half_end)
          state_nxt = IDLE;
      default:
        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      half_cnt   <= '0;
      sclk       <= 1'b0;
      done_pulse <= 1'b0;
      wr_frame   <= 1'b0;
    end
    else
    begin
      state      <= state_nxt;
      done_pulse <= (state == HOLD) && half_end;  // Lands with the return to IDLE.
      if ((state == IDLE) || half_end)
        half_cnt <= '0;
      else
        half_cnt <= half_cnt + 1'b1;
      if (rise)
        sclk <= 1'b1;
      else if (fall)
        sclk <= 1'b0;
      if (strobe.load)
        wr_frame <= cmd.write;
    end
  end

  assign busy = (state != IDLE);
  assign cs   = (state == IDLE);

  spi_tx_shifter u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .strobe  (strobe),
    .frame   (cmd),
    .mosi    (mosi),
    .tx_last (tx_last)
  );

  spi_rx_sampler u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .strobe  (strobe),
    .miso    (miso),
    .rx_byte (rd_byte),
    .rx_full (rx_full)
  );

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk);
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n) cmd_start |-> !busy);

endmodule

// ==== spi/spi_rx_sampler.sv ====
`include "spi_cfg.svh"

module spi_rx_sampler (
  input  logic                       clk,
  input  logic                       rst_n,
  input  spi_pkg::spi_strobe_t       strobe,
  input  logic                       miso,
  output logic [`SPI_READ_WIDTH-1:0] rx_byte,
  output logic                       rx_full
);

  localparam int CNT_W = $clog2(`SPI_READ_WIDTH + 1);

  logic [CNT_W-1:0] smp_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      smp_cnt <= '0;
    else if (strobe.load)
      smp_cnt <= '0;
    else if (strobe.sample && !rx_full)
      smp_cnt <= smp_cnt + 1'b1;
  end

  // MSB arrives first, so bits enter at the LSB end and move up.
  always_ff @(posedge clk)
  begin
    if (strobe.load)
      rx_byte <= '0;
    else if (strobe.sample && !rx_full)
      rx_byte <= {rx_byte[`SPI_READ_WIDTH-2:0], miso};
  end

  assign rx_full = (smp_cnt == CNT_W'(`SPI_READ_WIDTH));

endmodule

// ==== spi/spi_tx_shifter.sv ====
`include "spi_cfg.svh"

module spi_tx_shifter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  spi_pkg::spi_strobe_t strobe,
  input  spi_pkg::spi_cmd_t    frame,
  output logic                 mosi,
  output logic                 tx_last
);

  localparam int CNT_W = $clog2(`SPI_CMD_WIDTH + 1);

  logic [`SPI_CMD_WIDTH-1:0] shreg;
  logic [CNT_W-1:0]          bit_cnt;

  // bit_cnt counts bits already shifted past; it stops at the frame width.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg   <= '0;
      bit_cnt <= CNT_W'(`SPI_CMD_WIDTH);
    end
    else if (strobe.load)
    begin
      shreg   <= frame;
      bit_cnt <= '0;
    end
    else if (strobe.shift && (bit_cnt != CNT_W'(`SPI_CMD_WIDTH)))
    begin
      shreg   <= {shreg[`SPI_CMD_WIDTH-2:0], 1'b0};  // Zero fill keeps mosi low afterwards.
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign mosi    = shreg[`SPI_CMD_WIDTH-1];
  assign tx_last = (bit_cnt == CNT_W'(`SPI_CMD_WIDTH - 1));

endmodule
